/* Bender.yml */
package:
  name: axis_downsize

export_include_dirs:
  - .

sources:
  - files:
      - stream_pkg.sv
      - meta_pkg.sv
      - beat_fifo.sv
      - ingress_meter.sv
      - downsize_ctrl.sv
      - beat_slicer.sv
      - axis_downsize_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_axis_downsize.sv

/* axis_downsize_top.sv */
// AXI4-Stream downsizer, 256-bit beats to 64-bit words
// Beats and packet lengths wait in two fall-through FIFOs,
// the length goes out on tuser with fixed ports

`timescale 1ns/1ns

`include "conv_macros.svh"

module axis_downsize_top (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   // Input stream
   input  stream_pkg::in_data_t  s_axis_tdata,
   input  stream_pkg::in_strb_t  s_axis_tstrb,
   input  logic [`TUSER_W-1:0]   s_axis_tuser,   // Not used, tuser is regenerated
   input  logic                  s_axis_tvalid,
   output logic                  s_axis_tready,
   input  logic                  s_axis_tlast,
   // Output stream
   output stream_pkg::out_data_t m_axis_tdata,
   output stream_pkg::out_strb_t m_axis_tstrb,
   output meta_pkg::tuser_t      m_axis_tuser,
   output logic                  m_axis_tvalid,
   input  logic                  m_axis_tready,
   output logic                  m_axis_tlast
);

   import stream_pkg::*;
   import meta_pkg::*;

   in_beat_t  beat_head;
   len_t      len_in;
   len_t      len_head;
   lane_idx_t lane;
   logic      accept;
   logic      len_push;
   logic      beat_empty;
   logic      beat_nearly_full;
   logic      len_empty;
   logic      len_nearly_full;
   logic      pop_beat;
   logic      pop_len;
   logic      beat_last;
   logic      next_lane_empty;

   ////////////////////////////////////////
   // Input side
   ////////////////////////////////////////

   ingress_meter ingress_meter_i (
      .axi_aclk         (axi_aclk),
      .axi_resetn       (axi_resetn),
      .s_axis_tvalid    (s_axis_tvalid),
      .s_axis_tlast     (s_axis_tlast),
      .s_axis_tstrb     (s_axis_tstrb),
      .beat_nearly_full (beat_nearly_full),
      .len_nearly_full  (len_nearly_full),
      .s_axis_tready    (s_axis_tready),
      .accept           (accept),
      .len_push         (len_push),
      .len_out          (len_in)
   );

   beat_fifo #(
      .payload_t  (in_beat_t),
      .depth_bits (`BEAT_FIFO_DEPTH_BITS)
   ) beat_fifo_i (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .wr_en       (accept),
      .din         ({s_axis_tlast, s_axis_tstrb, s_axis_tdata}),  // Packed as in_beat_t
      .rd_en       (pop_beat),
      .dout        (beat_head),
      .empty       (beat_empty),
      .full        (),
      .nearly_full (beat_nearly_full)
   );

   beat_fifo #(
      .payload_t  (len_t),
      .depth_bits (`LEN_FIFO_DEPTH_BITS)
   ) len_fifo_i (
      .axi_aclk    (axi_aclk),
      .axi_resetn  (axi_resetn),
      .wr_en       (len_push),
      .din         (len_in),
      .rd_en       (pop_len),
      .dout        (len_head),
      .empty       (len_empty),
      .full        (),
      .nearly_full (len_nearly_full)
   );

   ////////////////////////////////////////
   // Output side
   ////////////////////////////////////////

   downsize_ctrl downsize_ctrl_i (
      .axi_aclk        (axi_aclk),
      .axi_resetn      (axi_resetn),
      .beat_empty      (beat_empty),
      .len_empty       (len_empty),
      .beat_last       (beat_last),
      .next_lane_empty (next_lane_empty),
      .m_axis_tready   (m_axis_tready),
      .lane            (lane),
      .m_axis_tvalid   (m_axis_tvalid),
      .m_axis_tlast    (m_axis_tlast),
      .pop_beat        (pop_beat),
      .pop_len         (pop_len)
   );

   beat_slicer beat_slicer_i (
      .beat            (beat_head),
      .lane            (lane),
      .len             (len_head),
      .m_axis_tdata    (m_axis_tdata),
      .m_axis_tstrb    (m_axis_tstrb),
      .m_axis_tuser    (m_axis_tuser),
      .beat_last       (beat_last),
      .next_lane_empty (next_lane_empty)
   );

endmodule

/* beat_fifo.sv */
// Fall-through FIFO on a circular buffer
// Head is valid while empty is low, flags are registered
// nearly_full leaves four free slots of margin

`timescale 1ns/1ns

module beat_fifo #(
   parameter type payload_t  = logic [7:0],
   parameter int  depth_bits = 4
) (
   input  logic     axi_aclk,
   input  logic     axi_resetn,
   input  logic     wr_en,
   input  payload_t din,
   input  logic     rd_en,
   output payload_t dout,
   output logic     empty,
   output logic     full,
   output logic     nearly_full
);

   localparam int DEPTH = 1 << depth_bits;

   payload_t              mem [DEPTH];
   logic [depth_bits-1:0] wr_ptr;
   logic [depth_bits-1:0] rd_ptr;
   logic [depth_bits:0]   count;
   logic [depth_bits:0]   count_next;
   logic                  do_wr;
   logic                  do_rd;

   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   assign dout = mem[rd_ptr];  // Fall-through head

   always_comb begin
      count_next = count;
      case ({do_wr, do_rd})
         2'b10:   count_next = count + 1'b1;
         2'b01:   count_next = count - 1'b1;
         default: count_next = count;
      endcase
   end

   // Storage, no reset
   always_ff @(posedge axi_aclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= din;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         empty       <= 1'b1;
         full        <= 1'b0;
         nearly_full <= 1'b0;
      end else begin
         if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // Pointers wrap
         if (do_rd) rd_ptr <= rd_ptr + 1'b1;
         count       <= count_next;
         empty       <= (count_next == '0);
         full        <= (count_next == (depth_bits+1)'(DEPTH));
         nearly_full <= (count_next >= (depth_bits+1)'(DEPTH - 4));
      end
   end

   // Upstream throttling must keep writes off a full FIFO
   a_no_write_full : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      wr_en |-> !full)
      else $error("beat_fifo: write while full");

   a_no_read_empty : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      rd_en |-> !empty)
      else $error("beat_fifo: read while empty");

endmodule

/* beat_slicer.sv */
// Lane slicer of the downsizer
// Picks one 64-bit lane of the head beat, checks the following lane
// for strobes and packs the metadata word

`timescale 1ns/1ns

`include "conv_macros.svh"

module beat_slicer (
   input  stream_pkg::in_beat_t  beat,
   input  stream_pkg::lane_idx_t lane,
   input  meta_pkg::len_t        len,
   output stream_pkg::out_data_t m_axis_tdata,
   output stream_pkg::out_strb_t m_axis_tstrb,
   output meta_pkg::tuser_t      m_axis_tuser,
   output logic                  beat_last,
   output logic                  next_lane_empty
);

   import stream_pkg::*;
   import meta_pkg::*;

   localparam int DW = $bits(out_data_t);
   localparam int SW = $bits(out_strb_t);

   lane_idx_t nxt_lane;   // Wraps on the final lane, masked below

   assign nxt_lane = lane + 1'b1;

   // Lowest lane first
   assign m_axis_tdata = beat.data[lane * DW +: DW];
   assign m_axis_tstrb = beat.strb[lane * SW +: SW];
   assign beat_last    = beat.last;

   assign next_lane_empty = (lane == lane_idx_t'(`LANES - 1)) ? 1'b0
                                                              : ~|beat.strb[nxt_lane * SW +: SW];

   ////////////////////////////////////////
   // Metadata word
   ////////////////////////////////////////

   always_comb begin
      m_axis_tuser          = '0;   // Zero padding
      m_axis_tuser.dst_port = port_t'(`DEFAULT_DST_PORT);
      m_axis_tuser.src_port = port_t'(`DEFAULT_SRC_PORT);
      m_axis_tuser.len      = len;
   end

endmodule

/* conv_macros.svh */
// Widths, FIFO depths and fixed metadata ports
// for the 256 to 64 bit AXI4-Stream downsizer

`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// Stream widths
`define IN_DATA_W  256
`define OUT_DATA_W 64
`define TUSER_W    128

// Metadata fields
`define LEN_W  16
`define PORT_W 8

// One 1600-byte packet fits in the beat FIFO
`define BEAT_FIFO_DEPTH_BITS 6
`define LEN_FIFO_DEPTH_BITS  5

`define DEFAULT_SRC_PORT 8'h01
`define DEFAULT_DST_PORT 8'h04

`define LANES (`IN_DATA_W / `OUT_DATA_W)  // Output words per input beat

`endif

/* downsize_ctrl.sv */
// Output FSM of the downsizer
// Waits for a whole packet, then steps through the lanes of each beat
// and pops the beat and length FIFOs at the right word

`timescale 1ns/1ns

`include "conv_macros.svh"

module downsize_ctrl (
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,
   input  logic                  beat_empty,
   input  logic                  len_empty,
   input  logic                  beat_last,
   input  logic                  next_lane_empty,
   input  logic                  m_axis_tready,
   output stream_pkg::lane_idx_t lane,
   output logic                  m_axis_tvalid,
   output logic                  m_axis_tlast,
   output logic                  pop_beat,
   output logic                  pop_len
);

   import stream_pkg::*;

   typedef enum logic {
      START,  // Wait for a complete packet
      BODY    // Stream lanes
   } state_t;

   state_t    state;
   state_t    state_next;
   lane_idx_t lane_next;
   logic      word_done;
   logic      end_of_beat;

   ////////////////////////////////////////
   // Output steering
   ////////////////////////////////////////

   assign m_axis_tvalid = (state == BODY) & ~beat_empty;
   assign word_done     = m_axis_tvalid & m_axis_tready;

   // Last lane, or an early end when the next lane of the last beat is empty
   assign end_of_beat = (lane == lane_idx_t'(`LANES - 1)) | (beat_last & next_lane_empty);

   assign m_axis_tlast = m_axis_tvalid & beat_last & end_of_beat;
   assign pop_beat     = word_done & end_of_beat;
   assign pop_len      = pop_beat & beat_last;   // Length held until the final word

   always_comb begin
      lane_next  = lane;
      state_next = state;
      if (word_done) begin
         lane_next = end_of_beat ? '0 : lane + 1'b1;
      end
      case (state)
         START: if (!beat_empty && !len_empty) state_next = BODY;
         BODY:  if (pop_len) state_next = START;
         default: state_next = START;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state <= START;
         lane  <= '0;
      end else begin
         state <= state_next;
         lane  <= lane_next;
      end
   end

   // AXI4-Stream rule, a presented word is not withdrawn
   a_valid_hold : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid)
      else $error("downsize_ctrl: m_axis_tvalid dropped before acceptance");

endmodule

/* flist.f */
+incdir+.
stream_pkg.sv
meta_pkg.sv
beat_fifo.sv
ingress_meter.sv
downsize_ctrl.sv
beat_slicer.sv
axis_downsize_top.sv
tb_clk_gen.sv
tb_axis_downsize.sv

/* ingress_meter.sv */
// Input side of the downsizer
// Registers tready from FIFO fill and counts packet bytes
// The length is pushed together with the tlast beat

`timescale 1ns/1ns

`include "conv_macros.svh"

module ingress_meter (
   input  logic                 axi_aclk,
   input  logic                 axi_resetn,
   input  logic                 s_axis_tvalid,
   input  logic                 s_axis_tlast,
   input  stream_pkg::in_strb_t s_axis_tstrb,
   input  logic                 beat_nearly_full,
   input  logic                 len_nearly_full,
   output logic                 s_axis_tready,
   output logic                 accept,
   output logic                 len_push,
   output meta_pkg::len_t       len_out
);

   import stream_pkg::*;
   import meta_pkg::*;

   localparam int STRB_W = $bits(in_strb_t);
   localparam int CNT_W  = $clog2(STRB_W) + 1;

   logic [CNT_W-1:0] beat_bytes;
   len_t             len_sum;   // Bytes of earlier beats in this packet

   ////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////

   // One cycle behind the FIFO flags, covered by the nearly_full margin
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         s_axis_tready <= 1'b0;
      end else begin
         s_axis_tready <= ~beat_nearly_full & ~len_nearly_full;
      end
   end

   assign accept   = s_axis_tvalid & s_axis_tready;
   assign len_push = accept & s_axis_tlast;

   ////////////////////////////////////////
   // Byte count
   ////////////////////////////////////////

   // Highest set strobe plus one, strobes assumed packed from byte 0
   always_comb begin
      beat_bytes = '0;
      for (int i = 0; i < STRB_W; i++) begin
         if (s_axis_tstrb[i]) begin
            beat_bytes = CNT_W'(i + 1);
         end
      end
   end

   assign len_out = len_sum + len_t'(beat_bytes);  // Final total on the tlast beat

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         len_sum <= '0;
      end else if (accept) begin
         if (s_axis_tlast) begin
            len_sum <= '0;   // Next packet starts fresh
         end else begin
            len_sum <= len_out;
         end
      end
   end

endmodule

/* meta_pkg.sv */
// Metadata types of the downsizer
// Packet length, port numbers and the 128-bit tuser word

`include "conv_macros.svh"

package meta_pkg;

   typedef logic [`LEN_W-1:0]  len_t;   // Byte count of one packet
   typedef logic [`PORT_W-1:0] port_t;

   localparam int PAD_W = `TUSER_W - `LEN_W - 2 * `PORT_W;

   // Length in the low bits, ports above, zero padding on top
   typedef struct packed {
      logic [PAD_W-1:0] pad;
      port_t            dst_port;
      port_t            src_port;
      len_t             len;
   } tuser_t;

endpackage

/* stream_pkg.sv */
// Stream types of the downsizer
// Input beats as stored in the beat FIFO, output words and lane index

`include "conv_macros.svh"

package stream_pkg;

   // Input side
   typedef logic [`IN_DATA_W-1:0]   in_data_t;
   typedef logic [`IN_DATA_W/8-1:0] in_strb_t;

   // Beat FIFO entry, last on top
   typedef struct packed {
      logic     last;
      in_strb_t strb;
      in_data_t data;
   } in_beat_t;

   // Output side
   typedef logic [`OUT_DATA_W-1:0]   out_data_t;
   typedef logic [`OUT_DATA_W/8-1:0] out_strb_t;

   typedef logic [$clog2(`LANES)-1:0] lane_idx_t;  // Which output lane of a beat

endpackage

/* tb_axis_downsize.sv */
// Testbench of the AXI4-Stream downsizer
// Random packets go in as 256-bit beats and the 64-bit words and tuser
// are checked against a queue of expected words built from the packet bytes

`timescale 1ns/1ns

`include "conv_macros.svh"

module tb_axis_downsize;

   localparam int NUM_PKTS       = 40;
   localparam int MAX_PKT_BYTES  = 200;
   localparam int CYCLES_PER_PKT = 200;
   localparam int RESET_CYCLES   = 10;
   localparam int DRIVE_DLY      = 10;    // ns after the rising edge
   localparam int STALL_AFTER    = 5;     // Packets in before the long stall
   localparam int STALL_CYCLES   = 300;
   localparam int IN_BYTES       = `IN_DATA_W / 8;
   localparam int OUT_BYTES      = `OUT_DATA_W / 8;
   localparam logic [31:0] SEED         = 32'h76086608;
   localparam logic [7:0]  EXP_SRC_PORT = 8'h01;
   localparam logic [7:0]  EXP_DST_PORT = 8'h04;

   logic                   axi_aclk;
   logic                   axi_resetn;
   logic [`IN_DATA_W-1:0]  s_axis_tdata;
   logic [IN_BYTES-1:0]    s_axis_tstrb;
   logic [`TUSER_W-1:0]    s_axis_tuser;
   logic                   s_axis_tvalid;
   logic                   s_axis_tready;
   logic                   s_axis_tlast;
   logic [`OUT_DATA_W-1:0] m_axis_tdata;
   logic [OUT_BYTES-1:0]   m_axis_tstrb;
   logic [`TUSER_W-1:0]    m_axis_tuser;
   logic                   m_axis_tvalid;
   logic                   m_axis_tready;
   logic                   m_axis_tlast;

   logic [`OUT_DATA_W-1:0] exp_data_q [$];   // Expected output words in arrival order
   logic [OUT_BYTES-1:0]   exp_strb_q [$];
   logic [`TUSER_W-1:0]    exp_tuser_q [$];
   logic                   exp_last_q [$];

   logic [7:0]  pkt_bytes [MAX_PKT_BYTES];
   logic [31:0] stim_lfsr;
   logic [31:0] ready_lfsr;
   int          pkts_in;    // Packets fully accepted at the input
   int          pkts_out;   // Packets whose tlast word went out
   logic        stall_active;
   logic        stall_done;
   logic        ready_fell = 1'b0;

   tb_clk_gen #(.PERIOD_NS(100), .RESET_CYCLES(RESET_CYCLES), .DRIVE_DLY(DRIVE_DLY)) clk_gen_i (
      .axi_aclk   (axi_aclk),
      .axi_resetn (axi_resetn)
   );

   axis_downsize_top dut_i (.*);

   ////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // Taps 32, 22, 2, 1
      return {s[30:0], fb};
   endfunction

   task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         state = lfsr_next(state);
         val   = {val[30:0], state[0]};
      end
   endtask

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at first error");
   endtask

   task automatic report_mismatch(input string sig, input logic [127:0] got,
                                  input logic [127:0] exp);
      abort_run($sformatf("ERR at %0t ns: %s is %0h, expected %0h", $time, sig, got, exp));
   endtask

   // One entry per 64-bit word with unused bytes as zero
   task automatic queue_expected(input int len);
      int                     nwords;
      int                     idx;
      logic [`OUT_DATA_W-1:0] data;
      logic [OUT_BYTES-1:0]   strb;
      nwords = (len + OUT_BYTES - 1) / OUT_BYTES;
      for (int w = 0; w < nwords; w++) begin
         data = '0;
         strb = '0;
         for (int k = 0; k < OUT_BYTES; k++) begin
            idx = w * OUT_BYTES + k;
            if (idx < len) begin
               data[8*k +: 8] = pkt_bytes[idx];
               strb[k]        = 1'b1;
            end
         end
         exp_data_q.push_back(data);
         exp_strb_q.push_back(strb);
         exp_tuser_q.push_back({{(`TUSER_W-32){1'b0}}, EXP_DST_PORT, EXP_SRC_PORT, 16'(len)});
         exp_last_q.push_back(w == nwords - 1);
      end
   endtask

   task automatic drive_beat(input logic [`IN_DATA_W-1:0] data, input logic [IN_BYTES-1:0] strb,
                             input logic last);
      logic [31:0] v;
      draw_bits(stim_lfsr, 2, v);
      while (v[1:0] == 2'b00) begin   // Idle cycle on tvalid
         s_axis_tvalid = 1'b0;
         @(posedge axi_aclk);
         #DRIVE_DLY;
         draw_bits(stim_lfsr, 2, v);
      end
      s_axis_tdata  = data;
      s_axis_tstrb  = strb;
      s_axis_tlast  = last;
      s_axis_tvalid = 1'b1;
      @(posedge axi_aclk);
      while (!s_axis_tready) @(posedge axi_aclk);
      #DRIVE_DLY;
      s_axis_tvalid = 1'b0;
   endtask

   task automatic send_packet();
      logic [31:0]           v;
      int                    len;
      int                    nbeats;
      int                    idx;
      logic [`IN_DATA_W-1:0] data;
      logic [IN_BYTES-1:0]   strb;
      draw_bits(stim_lfsr, 8, v);
      len = v % MAX_PKT_BYTES + 1;
      for (int i = 0; i < len; i++) begin
         draw_bits(stim_lfsr, 8, v);
         pkt_bytes[i] = v[7:0];
      end
      queue_expected(len);
      nbeats = (len + IN_BYTES - 1) / IN_BYTES;
      for (int b = 0; b < nbeats; b++) begin
         data = '0;
         strb = '0;
         for (int k = 0; k < IN_BYTES; k++) begin
            idx = b * IN_BYTES + k;
            if (idx < len) begin
               data[8*k +: 8] = pkt_bytes[idx];
               strb[k]        = 1'b1;   // Strobes packed from byte 0
            end
         end
         drive_beat(data, strb, b == nbeats - 1);
      end
   endtask

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   initial begin : stimulus
      s_axis_tdata  = '0;
      s_axis_tstrb  = '0;
      s_axis_tuser  = {4{32'h5a5ac3c3}};   // Ignored by the DUT
      s_axis_tvalid = 1'b0;
      s_axis_tlast  = 1'b0;
      stim_lfsr     = SEED;
      wait (axi_resetn === 1'b1);
      @(posedge axi_aclk);
      #DRIVE_DLY;
      for (int p = 0; p < NUM_PKTS; p++) send_packet();
      wait (pkts_out == NUM_PKTS);
      repeat (4) @(posedge axi_aclk);   // Room for any stray word
      if (ready_fell) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         abort_run("s_axis_tready never fell during the long m_axis_tready stall");
      end
   end

   initial begin : ready_drive
      logic [31:0] v;
      m_axis_tready = 1'b0;
      ready_lfsr    = SEED;
      stall_active  = 1'b0;
      stall_done    = 1'b0;
      wait (axi_resetn === 1'b1);
      forever begin
         @(posedge axi_aclk);
         #DRIVE_DLY;
         if (!stall_done && pkts_in >= STALL_AFTER) begin
            stall_active  = 1'b1;   // Long back-pressure fills the FIFOs
            m_axis_tready = 1'b0;
            repeat (STALL_CYCLES) @(posedge axi_aclk);
            #DRIVE_DLY;
            stall_active = 1'b0;
            stall_done   = 1'b1;
         end else begin
            draw_bits(ready_lfsr, 2, v);
            m_axis_tready = (v[1:0] != 2'b00);   // High three cycles in four
         end
      end
   end

   initial begin : watchdog
      repeat (RESET_CYCLES + NUM_PKTS * CYCLES_PER_PKT) @(posedge axi_aclk);
      abort_run("Watchdog timeout, not all packets came out of the DUT");
   end

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////

   always @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         pkts_in  <= 0;
         pkts_out <= 0;
      end else begin
         if (s_axis_tvalid && s_axis_tready && s_axis_tlast) pkts_in <= pkts_in + 1;
         if (stall_active && !s_axis_tready) ready_fell <= 1'b1;
         if (m_axis_tvalid && m_axis_tready) begin
            assert (exp_data_q.size() > 0)
               else abort_run("Output word arrived while no word was expected");
            assert (m_axis_tdata == exp_data_q[0])
               else report_mismatch("m_axis_tdata", m_axis_tdata, exp_data_q[0]);
            assert (m_axis_tstrb == exp_strb_q[0])
               else report_mismatch("m_axis_tstrb", m_axis_tstrb, exp_strb_q[0]);
            assert (m_axis_tuser == exp_tuser_q[0])
               else report_mismatch("m_axis_tuser", m_axis_tuser, exp_tuser_q[0]);
            assert (m_axis_tlast == exp_last_q[0])
               else report_mismatch("m_axis_tlast", m_axis_tlast, exp_last_q[0]);
            if (m_axis_tlast) pkts_out <= pkts_out + 1;
            void'(exp_data_q.pop_front());
            void'(exp_strb_q.pop_front());
            void'(exp_tuser_q.pop_front());
            void'(exp_last_q.pop_front());
         end
      end
   end

   // Output only once a whole packet sits in the DUT
   a_no_early_valid : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      m_axis_tvalid |-> pkts_in > pkts_out)
      else abort_run("m_axis_tvalid rose before a complete packet was accepted");

   a_word_hold : assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata) &&
      $stable(m_axis_tstrb) && $stable(m_axis_tuser) && $stable(m_axis_tlast))
      else abort_run("Output word changed while m_axis_tready was low");

endmodule

/* tb_clk_gen.sv */
// Testbench clock and reset source
// Free running clock, active low reset released after a fixed number of cycles

`timescale 1ns/1ns

module tb_clk_gen #(
   parameter int PERIOD_NS    = 100,
   parameter int RESET_CYCLES = 10,
   parameter int DRIVE_DLY    = 10
) (
   output logic axi_aclk,
   output logic axi_resetn
);

   initial axi_aclk = 1'b0;
   always #(PERIOD_NS / 2) axi_aclk = ~axi_aclk;

   initial begin
      axi_resetn = 1'b0;
      repeat (RESET_CYCLES) @(posedge axi_aclk);
      #DRIVE_DLY;
      axi_resetn = 1'b1;   // Released off the edge like other stimulus
   end

endmodule
